/* files.f */
verilog/lsu_pkg.sv
verilog/lsu_request_stage.sv
verilog/agu.sv
verilog/data_ram.sv
verilog/load_align.sv
verilog/lsu_top.sv
verification/lsu_tb.sv

/* Makefile */
# Verilator build and run for the lsu testbench.
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := lsu_tb
FILELIST  := files.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Finished with errors
PASS_MSG  := Finished with no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation did not complete"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verification/lsu_tb.sv */
// lsu testbench driving table requests through lsu_top with an in-order response checker.
`default_nettype none
`timescale 1ns/1ps

module lsu_tb;

  localparam int RESET_CYCLES = 4;  // arst_n low for this many clocks.
  localparam int LATENCY      = 2;  // clocks from the sampling edge to rsp_valid.
  localparam int IDLE_CYCLES  = 4;  // quiet time to catch stray responses.

  // one stimulus row with its hand computed response.
  typedef struct packed {
    lsu_pkg::mem_op_t op;
    logic [31:0]      base;
    logic [31:0]      offset;
    logic [31:0]      wdata;
    logic [31:0]      rdata;  // expected rsp_rdata.
    logic             fault;  // expected rsp_fault.
  } row_t;

  // response still owed by the dut.
  typedef struct packed {
    logic [31:0] rdata;
    logic        fault;
    int          issue_cycle;  // cycle count at the sampling edge.
    int          row;
  } exp_t;

  logic             clk;
  logic             arst_n;
  logic             req_valid;
  lsu_pkg::mem_op_t req_op;
  logic [31:0]      req_base;
  logic [31:0]      req_offset;
  logic [31:0]      req_wdata;
  logic             rsp_valid;
  logic [31:0]      rsp_rdata;
  logic             rsp_fault;

  row_t stim[$];            // stimulus table.
  exp_t exp_q[$];           // outstanding responses with the oldest first.
  int   cycle_count = 0;    // rising edges since time zero.
  int   cycle_limit = 0;    // watchdog bound set once the table is built.
  int   rsp_count   = 0;    // responses checked so far.

  lsu_top lsu_top_inst (
    .clk        (clk),
    .arst_n     (arst_n),
    .req_valid  (req_valid),
    .req_op     (req_op),
    .req_base   (req_base),
    .req_offset (req_offset),
    .req_wdata  (req_wdata),
    .rsp_valid  (rsp_valid),
    .rsp_rdata  (rsp_rdata),
    .rsp_fault  (rsp_fault)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period.
  end

  // print what went wrong, then the fail line, then stop.
  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic add_row(input lsu_pkg::mem_op_t op, input logic [31:0] base,
                         input logic [31:0] offset, input logic [31:0] wdata,
                         input logic [31:0] rdata, input logic fault);
    stim.push_back('{op, base, offset, wdata, rdata, fault});
  endtask

  task automatic build_table();
    // word store then load through a negative offset.
    add_row(lsu_pkg::OP_SW,  32'h0000_0110, 32'hFFFF_FFF0, 32'hDEAD_BEEF, 32'h0, 1'b0);
    add_row(lsu_pkg::OP_LW,  32'h0000_0104, 32'hFFFF_FFFC, 32'h0, 32'hDEAD_BEEF, 1'b0);
    // four byte lanes of word 0x200 with upper wdata bits dropped.
    add_row(lsu_pkg::OP_SB,  32'h0000_0200, 32'h0, 32'h0000_0011, 32'h0, 1'b0);
    add_row(lsu_pkg::OP_SB,  32'h0000_0200, 32'h1, 32'h1234_5622, 32'h0, 1'b0);
    add_row(lsu_pkg::OP_SB,  32'h0000_0200, 32'h2, 32'h0000_0080, 32'h0, 1'b0);
    add_row(lsu_pkg::OP_SB,  32'h0000_0200, 32'h3, 32'h0000_0044, 32'h0, 1'b0);
    add_row(lsu_pkg::OP_LW,  32'h0000_0200, 32'h0, 32'h0, 32'h4480_2211, 1'b0);
    add_row(lsu_pkg::OP_LB,  32'h0000_0200, 32'h2, 32'h0, 32'hFFFF_FF80, 1'b0);
    add_row(lsu_pkg::OP_LBU, 32'h0000_0200, 32'h2, 32'h0, 32'h0000_0080, 1'b0);
    add_row(lsu_pkg::OP_LB,  32'h0000_0200, 32'h1, 32'h0, 32'h0000_0022, 1'b0);
    // halfwords at offsets 0 and 2 of word 0x300.
    add_row(lsu_pkg::OP_SH,  32'h0000_0300, 32'h0, 32'h0000_8001, 32'h0, 1'b0);
    add_row(lsu_pkg::OP_SH,  32'h0000_0300, 32'h2, 32'hABCD_7FFE, 32'h0, 1'b0);
    add_row(lsu_pkg::OP_LH,  32'h0000_0300, 32'h0, 32'h0, 32'hFFFF_8001, 1'b0);
    add_row(lsu_pkg::OP_LHU, 32'h0000_0300, 32'h0, 32'h0, 32'h0000_8001, 1'b0);
    add_row(lsu_pkg::OP_LH,  32'h0000_0300, 32'h2, 32'h0, 32'h0000_7FFE, 1'b0);
    add_row(lsu_pkg::OP_LW,  32'h0000_0300, 32'h0, 32'h0, 32'h7FFE_8001, 1'b0);
    // misaligned accesses fault with zero data.
    add_row(lsu_pkg::OP_LW,  32'h0000_0100, 32'h1, 32'h0, 32'h0, 1'b1);
    add_row(lsu_pkg::OP_LH,  32'h0000_0300, 32'h3, 32'h0, 32'h0, 1'b1);
    add_row(lsu_pkg::OP_SW,  32'h0000_0100, 32'h2, 32'hCAFE_F00D, 32'h0, 1'b1);
    add_row(lsu_pkg::OP_LW,  32'h0000_0100, 32'h0, 32'h0, 32'hDEAD_BEEF, 1'b0);  // untouched.
    // load right behind a store to the same word.
    add_row(lsu_pkg::OP_SW,  32'h0000_0040, 32'h0, 32'h1357_9BDF, 32'h0, 1'b0);
    add_row(lsu_pkg::OP_LW,  32'h0000_0040, 32'h0, 32'h0, 32'h1357_9BDF, 1'b0);
    add_row(lsu_pkg::OP_SB,  32'h0000_0040, 32'h1, 32'h0000_00AA, 32'h0, 1'b0);
    add_row(lsu_pkg::OP_LW,  32'h0000_0040, 32'h0, 32'h0, 32'h1357_AADF, 1'b0);
    // addresses 1 KiB apart hit the same word.
    add_row(lsu_pkg::OP_LW,  32'h0000_0500, 32'h0, 32'h0, 32'hDEAD_BEEF, 1'b0);
    add_row(lsu_pkg::OP_SW,  32'h0000_0640, 32'h0, 32'h55AA_55AA, 32'h0, 1'b0);
    add_row(lsu_pkg::OP_LW,  32'h0000_0240, 32'h0, 32'h0, 32'h55AA_55AA, 1'b0);
    add_row(lsu_pkg::OP_LW,  32'h8000_0000, 32'h300, 32'h0, 32'h7FFE_8001, 1'b0);
  endtask

  // cycle counter and watchdog.
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
      stop_with_failure($sformatf("timeout: %0d of %0d responses seen after %0d cycles",
                                  rsp_count, stim.size(), cycle_count));
    end
  end

  // outputs are registered at the rising edge, so the falling edge sees them settled.
  always @(negedge clk) begin : check_responses
    exp_t exp_rsp;
    if (arst_n && rsp_valid) begin
      assert (exp_q.size() != 0)
        else stop_with_failure("a response arrived with no request outstanding");
      exp_rsp = exp_q.pop_front();
      assert (cycle_count == exp_rsp.issue_cycle + LATENCY)
        else stop_with_failure($sformatf("Error at %0t: row %0d latency %0d, expected %0d",
                               $time, exp_rsp.row, cycle_count - exp_rsp.issue_cycle, LATENCY));
      assert (rsp_fault == exp_rsp.fault)
        else stop_with_failure($sformatf("Error at %0t: row %0d rsp_fault %b, expected %b",
                               $time, exp_rsp.row, rsp_fault, exp_rsp.fault));
      assert (rsp_rdata == exp_rsp.rdata)
        else stop_with_failure($sformatf("Error at %0t: row %0d rsp_rdata %h, expected %h",
                               $time, exp_rsp.row, rsp_rdata, exp_rsp.rdata));
      rsp_count++;
    end
  end

  initial begin
    arst_n     = 1'b0;
    req_valid  = 1'b0;
    req_op     = lsu_pkg::OP_LW;
    req_base   = '0;
    req_offset = '0;
    req_wdata  = '0;
    build_table();
    cycle_limit = stim.size() + 20 + RESET_CYCLES;

    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    // back to back with one row per clock.
    for (int i = 0; i < stim.size(); i++) begin
      @(negedge clk);
      req_valid  = 1'b1;
      req_op     = stim[i].op;
      req_base   = stim[i].base;
      req_offset = stim[i].offset;
      req_wdata  = stim[i].wdata;
      exp_q.push_back('{stim[i].rdata, stim[i].fault, cycle_count + 1, i});  // next edge samples.
    end
    @(negedge clk);
    req_valid = 1'b0;

    // the last request answers a fixed LATENCY after it is sampled.
    repeat (LATENCY + IDLE_CYCLES) @(negedge clk);

    if (exp_q.size() != 0) begin
      stop_with_failure($sformatf("%0d expected responses never arrived", exp_q.size()));
    end else begin
      $display("Finished with no errors");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* verilog/lsu_top.sv */
// rv32i load/store unit top joining the request register, agu, data ram and load alignment.
`default_nettype none
`timescale 1ns/1ps

module lsu_top (
  input  wire logic                       clk,
  input  wire logic                       arst_n,
  input  wire logic                       req_valid,
  input  wire lsu_pkg::mem_op_t           req_op,
  input  wire logic [lsu_pkg::ADDR_W-1:0] req_base,
  input  wire logic [lsu_pkg::ADDR_W-1:0] req_offset,
  input  wire logic [lsu_pkg::DATA_W-1:0] req_wdata,
  output logic                            rsp_valid,   // two clocks after the request.
  output logic [lsu_pkg::DATA_W-1:0]      rsp_rdata,
  output logic                            rsp_fault
);

  logic                       s1_valid;
  lsu_pkg::mem_op_t           s1_op;
  logic [lsu_pkg::ADDR_W-1:0] s1_base;
  logic [lsu_pkg::ADDR_W-1:0] s1_offset;
  logic [lsu_pkg::DATA_W-1:0] s1_wlanes;
  logic [lsu_pkg::ADDR_W-1:0] address;     // combinational effective address.
  logic [lsu_pkg::BE_W-1:0]   byte_en;
  logic                       misaligned;
  logic [lsu_pkg::DATA_W-1:0] rdata_word;  // ram read word.

  lsu_request_stage lsu_request_stage_inst (
    .clk        (clk),
    .arst_n     (arst_n),
    .req_valid  (req_valid),
    .req_op     (req_op),
    .req_base   (req_base),
    .req_offset (req_offset),
    .req_wdata  (req_wdata),
    .s1_valid   (s1_valid),
    .s1_op      (s1_op),
    .s1_base    (s1_base),
    .s1_offset  (s1_offset),
    .s1_wlanes  (s1_wlanes)
  );

  agu agu_inst (
    .s1_valid   (s1_valid),
    .s1_op      (s1_op),
    .s1_base    (s1_base),
    .s1_offset  (s1_offset),
    .address    (address),
    .byte_en    (byte_en),
    .misaligned (misaligned)
  );

  data_ram data_ram_inst (
    .clk        (clk),
    .s1_valid   (s1_valid),
    .s1_op      (s1_op),
    .address    (address),
    .byte_en    (byte_en),
    .misaligned (misaligned),
    .s1_wlanes  (s1_wlanes),
    .rdata_word (rdata_word)
  );

  load_align load_align_inst (
    .clk        (clk),
    .arst_n     (arst_n),
    .s1_valid   (s1_valid),
    .s1_op      (s1_op),
    .addr_lo    (address[1:0]),  // lane select for the s2 side.
    .misaligned (misaligned),
    .rdata_word (rdata_word),
    .rsp_valid  (rsp_valid),
    .rsp_rdata  (rsp_rdata),
    .rsp_fault  (rsp_fault)
  );

endmodule

`default_nettype wire

/* verilog/load_align.sv */
// load alignment that picks the addressed bytes, extends them and registers the response.
`default_nettype none
`timescale 1ns/1ps

module load_align (
  input  wire logic                       clk,
  input  wire logic                       arst_n,
  input  wire logic                       s1_valid,
  input  wire lsu_pkg::mem_op_t           s1_op,
  input  wire logic [1:0]                 addr_lo,     // address bits 1:0 of the s1 request.
  input  wire logic                       misaligned,
  input  wire logic [lsu_pkg::DATA_W-1:0] rdata_word,  // ram read that lines up with s2.
  output logic                            rsp_valid,
  output logic [lsu_pkg::DATA_W-1:0]      rsp_rdata,
  output logic                            rsp_fault
);

  logic                       s2_valid;   // request sits alongside rdata_word.
  lsu_pkg::mem_op_t           s2_op;
  logic [1:0]                 s2_addr_lo;
  logic                       s2_fault;
  logic [lsu_pkg::BYTE_W-1:0] sel_byte;   // addressed byte.
  logic [lsu_pkg::HALF_W-1:0] sel_half;   // addressed halfword.
  logic [lsu_pkg::DATA_W-1:0] load_data;  // extended result.

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s2_valid <= 1'b0;
    end else begin
      s2_valid <= s1_valid;
    end
  end

  // s2 copies taken at the same edge as the ram read.
  always_ff @(posedge clk) begin
    if (s1_valid) begin
      s2_op      <= s1_op;
      s2_addr_lo <= addr_lo;
      s2_fault   <= misaligned;
    end
  end

  assign sel_byte = rdata_word[{s2_addr_lo, 3'b000} +: lsu_pkg::BYTE_W];
  assign sel_half = s2_addr_lo[1] ? rdata_word[lsu_pkg::DATA_W-1 -: lsu_pkg::HALF_W]
                                  : rdata_word[lsu_pkg::HALF_W-1:0];

  always_comb begin
    case (s2_op)
      lsu_pkg::OP_LB:  load_data = {{(lsu_pkg::DATA_W-lsu_pkg::BYTE_W){sel_byte[7]}}, sel_byte};
      lsu_pkg::OP_LBU: load_data = {{(lsu_pkg::DATA_W-lsu_pkg::BYTE_W){1'b0}}, sel_byte};
      lsu_pkg::OP_LH:  load_data = {{(lsu_pkg::DATA_W-lsu_pkg::HALF_W){sel_half[15]}}, sel_half};
      lsu_pkg::OP_LHU: load_data = {{(lsu_pkg::DATA_W-lsu_pkg::HALF_W){1'b0}}, sel_half};
      lsu_pkg::OP_LW:  load_data = rdata_word;
      default:         load_data = '0; // stores return zero.
    endcase
    if (s2_fault) begin
      load_data = '0; // no data on a fault.
    end
  end

  // response flags.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rsp_valid <= 1'b0;
      rsp_fault <= 1'b0;
    end else begin
      rsp_valid <= s2_valid;
      rsp_fault <= s2_valid && s2_fault;
    end
  end

  always_ff @(posedge clk) begin
    if (s2_valid) begin
      rsp_rdata <= load_data;
    end
  end

  a_fault_has_valid: assert property (
    @(posedge clk) disable iff (!arst_n)
    rsp_fault |-> (rsp_valid && (rsp_rdata == '0))
  ) else $error("rsp_fault without rsp_valid or with nonzero data");

endmodule

`default_nettype wire

/* verilog/data_ram.sv */
// data ram of 256 words with byte lane writes and a registered read of old data on collision.
`default_nettype none
`timescale 1ns/1ps

module data_ram (
  input  wire logic                       clk,
  input  wire logic                       s1_valid,
  input  wire lsu_pkg::mem_op_t           s1_op,
  input  wire logic [lsu_pkg::ADDR_W-1:0] address,
  input  wire logic [lsu_pkg::BE_W-1:0]   byte_en,
  input  wire logic                       misaligned,
  input  wire logic [lsu_pkg::DATA_W-1:0] s1_wlanes,
  output logic [lsu_pkg::DATA_W-1:0]      rdata_word   // valid one clock after the access.
);

  logic [lsu_pkg::DATA_W-1:0]    mem [lsu_pkg::RAM_WORDS]; // contents are not reset.
  logic [lsu_pkg::RAM_IDX_W-1:0] idx;     // word index with upper address bits dropped.
  logic                          wr;      // aligned store this cycle.
  logic [lsu_pkg::BE_W-1:0]      lane_we; // per lane write strobes.

  assign idx     = address[lsu_pkg::RAM_IDX_W+1:2]; // wraps every 1 KiB.
  assign wr      = s1_valid && lsu_pkg::is_store(s1_op) && !misaligned;
  assign lane_we = byte_en & {lsu_pkg::BE_W{wr}};

  // lane writes.
  always_ff @(posedge clk) begin
    for (int i = 0; i < lsu_pkg::BE_W; i++) begin
      if (lane_we[i]) begin
        mem[idx][i*lsu_pkg::BYTE_W +: lsu_pkg::BYTE_W] <= s1_wlanes[i*lsu_pkg::BYTE_W +:
                                                                     lsu_pkg::BYTE_W];
      end
    end
  end

  // registered read sees the old word on a same edge write.
  always_ff @(posedge clk) begin
    if (s1_valid) begin
      rdata_word <= mem[idx];
    end
  end

  // the agu clears byte_en on a fault before wr gates it here.
  a_no_write_on_fault: assert property (
    @(posedge clk)
    misaligned |-> (byte_en == '0)
  ) else $error("byte_en active on a misaligned access");

endmodule

`default_nettype wire

/* verilog/agu.sv */
// address generation unit forming the effective address, lane enables and alignment check.
`default_nettype none
`timescale 1ns/1ps

module agu (
  input  wire logic                       s1_valid,
  input  wire lsu_pkg::mem_op_t           s1_op,
  input  wire logic [lsu_pkg::ADDR_W-1:0] s1_base,
  input  wire logic [lsu_pkg::ADDR_W-1:0] s1_offset,
  output logic [lsu_pkg::ADDR_W-1:0]      address,    // base + offset wrapping mod 2^32.
  output logic [lsu_pkg::BE_W-1:0]        byte_en,    // lanes touched or zero on a fault.
  output logic                            misaligned  // only high for a valid request.
);

  logic [1:0] addr_lo;   // byte offset inside the word.
  logic       align_err; // width vs offset check before the valid gate.

  assign address = s1_base + s1_offset; // plain add handles a negative offset.
  assign addr_lo = address[1:0];

  always_comb begin
    // defaults cover the byte group.
    align_err = 1'b0;
    byte_en   = 4'b0001 << addr_lo; // single lane picked by the low bits.

    case (s1_op)
      lsu_pkg::OP_LW,
      lsu_pkg::OP_SW: begin
        align_err = (addr_lo != 2'b00); // word must sit on a word boundary.
        byte_en   = 4'b1111;
      end
      lsu_pkg::OP_LH,
      lsu_pkg::OP_LHU,
      lsu_pkg::OP_SH: begin
        align_err = addr_lo[0]; // half must sit on an even byte.
        byte_en   = addr_lo[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        align_err = 1'b0; // a byte never straddles.
      end
    endcase

    misaligned = s1_valid && align_err;

    if (misaligned) begin
      byte_en = '0; // faulting access touches nothing.
    end

    // the lane at the byte offset is always part of an aligned access.
    a_lane_at_offset: assert (!s1_valid || misaligned || byte_en[addr_lo])
      else $error("byte_en misses the addressed lane");
  end

  // this unit has no state. All outputs settle between the
  // request register edge and the ram edge, so the ram index and
  // the fault flag seen by load_align belong to the same request.

endmodule

`default_nettype wire

/* verilog/lsu_request_stage.sv */
// lsu input register that samples a request and spreads store data over the byte lanes.
`default_nettype none
`timescale 1ns/1ps

module lsu_request_stage (
  input  wire logic                       clk,
  input  wire logic                       arst_n,
  input  wire logic                       req_valid,  // one strobe per request.
  input  wire lsu_pkg::mem_op_t           req_op,
  input  wire logic [lsu_pkg::ADDR_W-1:0] req_base,
  input  wire logic [lsu_pkg::ADDR_W-1:0] req_offset,
  input  wire logic [lsu_pkg::DATA_W-1:0] req_wdata,
  output logic                            s1_valid,
  output lsu_pkg::mem_op_t                s1_op,
  output logic [lsu_pkg::ADDR_W-1:0]      s1_base,
  output logic [lsu_pkg::ADDR_W-1:0]      s1_offset,
  output logic [lsu_pkg::DATA_W-1:0]      s1_wlanes   // lane replicated store data.
);

  logic [lsu_pkg::DATA_W-1:0] wlanes_next; // replicated store data before the register.

  // replicate the store operand so every lane the ram may enable holds it.
  always_comb begin
    case (req_op)
      lsu_pkg::OP_SB: begin
        wlanes_next = {lsu_pkg::BE_W{req_wdata[lsu_pkg::BYTE_W-1:0]}}; // byte in all lanes.
      end
      lsu_pkg::OP_SH: begin
        wlanes_next = {2{req_wdata[lsu_pkg::HALF_W-1:0]}}; // half in both halves.
      end
      default: begin
        wlanes_next = req_wdata; // word store and don't care for loads.
      end
    endcase
  end

  // valid is the only control bit here.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= req_valid; // one request per cycle with no stall.
    end
  end

  // payload follows the strobe.
  always_ff @(posedge clk) begin
    if (req_valid) begin
      s1_op     <= req_op;
      s1_base   <= req_base;
      s1_offset <= req_offset;
      s1_wlanes <= wlanes_next;
    end
  end

  // valid drives ram writes and the response count downstream.
  a_s1_valid_known: assert property (
    @(posedge clk) disable iff (!arst_n)
    !$isunknown(s1_valid)
  ) else $error("s1_valid unknown after reset");

endmodule

`default_nettype wire

/* verilog/lsu_pkg.sv */
// shared lsu definitions for the memory op encoding, datapath widths and ram geometry.
`default_nettype none

package lsu_pkg;

  localparam int ADDR_W    = 32;  // base, offset and effective address.
  localparam int DATA_W    = 32;  // store and load data.
  localparam int BE_W      = 4;   // one enable per byte lane.
  localparam int BYTE_W    = 8;   // lane width.
  localparam int HALF_W    = 16;  // halfword width.
  localparam int RAM_WORDS = 256; // data ram depth in words.
  localparam int RAM_IDX_W = 8;   // word index taken from address[9:2].

  // access kind with its width and signedness.
  typedef enum logic [2:0] {
    OP_LB  = 3'd0, // signed byte load.
    OP_LH  = 3'd1, // signed halfword load.
    OP_LW  = 3'd2, // word load.
    OP_LBU = 3'd3, // unsigned byte load.
    OP_LHU = 3'd4, // unsigned halfword load.
    OP_SB  = 3'd5, // byte store.
    OP_SH  = 3'd6, // halfword store.
    OP_SW  = 3'd7  // word store.
  } mem_op_t;

  // true for the three store kinds.
  function automatic logic is_store(input mem_op_t op);
    logic st;
    case (op)
      OP_SB,
      OP_SH,
      OP_SW:   st = 1'b1; // writes memory.
      default: st = 1'b0; // every load.
    endcase
    return st;
  endfunction

  // byte ops are LB, LBU and SB, half ops are LH, LHU and SH, word ops are LW and SW.
  // the address unit and the store lane builder both key off these groups.

endpackage

`default_nettype wire
